// ==== mips_pipe.f ====
hw/mips_pkg.sv
hw/control_decoder.sv
hw/register_file.sv
hw/pipe_reg.sv
hw/hazard_unit.sv
hw/execute_stage.sv
hw/mips_pipeline.sv
bench/mips_asserts.sv
bench/tb_mips.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory and the log"

obj_dir/tb_mips: mips_pipe.f hw/*.sv bench/*.sv
	verilator --binary --assert --timescale 1ns/1ps --top-module tb_mips -f mips_pipe.f -o tb_mips

test: obj_dir/tb_mips
	./obj_dir/tb_mips > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "TESTS FAILED" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

// ==== bench/tb_mips.sv ====
`default_nettype none

module tb_mips;
  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [31:0] done_addr       = 32'h0000_03fc;   // Last store of every program
  localparam int          watchdog_margin = 100;

  logic        clk = 1'b0;
  logic        reset = 1'b1;
  logic [31:0] imem_addr;
  logic [31:0] imem_data = '0;
  logic [31:0] dmem_addr;
  logic [31:0] dmem_wdata;
  logic        dmem_we;
  logic [31:0] dmem_rdata = '0;

  logic [31:0] imem [256];
  logic [31:0] dmem [256];
  logic [31:0] prog [$];
  logic [31:0] exp_addr [$];
  logic [31:0] exp_data [$];
  logic [31:0] store_addr [$];
  logic [31:0] store_data [$];

  int done_count = 0;
  int done_target = 0;
  int store_base = 0;
  int instr_total = 0;
  int cycle_count = 0;
  int error_count = 0;
  int check_count = 0;
  int tests_run = 0;
  int tests_bad = 0;
  int test_err_start = 0;

  mips_pipeline uut (
    .clk        (clk),
    .reset      (reset),
    .imem_addr  (imem_addr),
    .imem_data  (imem_data),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_we    (dmem_we),
    .dmem_rdata (dmem_rdata)
  );

  initial
  begin
    forever #4 clk = ~clk;
  end

  // ------------------------------------------------------------
  // Memory models driven on the falling edge
  // ------------------------------------------------------------
  always @(negedge clk)
  begin
    if (dmem_we)
    begin
      dmem[dmem_addr[9:2]] = dmem_wdata;
      if (dmem_addr == done_addr)
        done_count++;                       // Program finished
      else
      begin
        store_addr.push_back(dmem_addr);
        store_data.push_back(dmem_wdata);
      end
    end
    imem_data  = imem[imem_addr[9:2]];
    dmem_rdata = dmem[dmem_addr[9:2]];
  end

  // Budget grows as programs are loaded
  initial
  begin
    while (cycle_count <= instr_total * 4 + watchdog_margin)
    begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Watchdog expired after %0d cycles, the run did not complete", cycle_count);
    $display("TESTS FAILED");
    $finish;
  end

  function automatic logic [31:0] sext16(input logic [15:0] v);
    return {{16{v[15]}}, v};
  endfunction

  function automatic logic [15:0] rand16();
    logic [31:0] r;
    r = $urandom;
    return r[15:0];
  endfunction

  function automatic logic [31:0] r_type(input int rs, input int rt, input int rd,
                                         input logic [5:0] funct);
    return {mips_pkg::op_rtype, rs[4:0], rt[4:0], rd[4:0], 5'd0, funct};
  endfunction

  function automatic logic [31:0] i_type(input logic [5:0] op, input int rs, input int rt,
                                         input logic [15:0] imm);
    return {op, rs[4:0], rt[4:0], imm};
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] expected);
    check_count++;
    if (got !== expected)
    begin
      $display("[FAIL] %0t %s got %h expected %h", $time, name, got, expected);
      error_count++;
    end
  endtask

  task automatic new_program();
    prog.delete();
    exp_addr.delete();
    exp_data.delete();
    test_err_start = error_count;
  endtask

  task automatic emit(input logic [31:0] w);
    prog.push_back(w);
  endtask

  task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
  endtask

  // Program loads while reset is held for 2 cycles
  task automatic launch();
    prog.push_back(i_type(mips_pkg::op_sw, 0, 0, done_addr[15:0]));
    @(negedge clk);
    reset = 1'b1;
    @(posedge clk);
    for (int i = 0; i < 256; i++)
      imem[i] = '0;                       // Zero word decodes as a no-op
    foreach (prog[i])
      imem[i] = prog[i];
    instr_total += prog.size();
    store_base  = store_addr.size();
    done_target = done_count + 1;
    @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
  endtask

  task automatic finish_test(input string name);
    int waited;
    int limit;
    int got_n;
    int n;
    waited = 0;
    limit  = prog.size() * 4 + 40;
    while (done_count < done_target && waited < limit)
    begin
      @(posedge clk);
      waited++;
    end
    if (done_count < done_target)
    begin
      $display("%s: program did not reach its final store within %0d cycles", name, limit);
      error_count++;
    end
    else
    begin
      got_n = store_addr.size() - store_base;
      check("store count", got_n, exp_addr.size());
      n = (got_n < exp_addr.size()) ? got_n : exp_addr.size();
      for (int i = 0; i < n; i++)
      begin
        check($sformatf("dmem_addr[%0d]", i), store_addr[store_base + i], exp_addr[i]);
        check($sformatf("dmem_wdata[%0d]", i), store_data[store_base + i], exp_data[i]);
      end
    end
    tests_run++;
    if (error_count == test_err_start)
      $display("%s: ok", name);
    else
    begin
      tests_bad++;
      $display("%s: %0d errors", name, error_count - test_err_start);
    end
  endtask

  // ------------------------------------------------------------
  // Directed tests
  // ------------------------------------------------------------
  task automatic test_alu_ops();
    logic [15:0] ia;
    logic [15:0] ib;
    logic [15:0] ic;
    logic [31:0] va;
    logic [31:0] vb;
    ia = rand16();
    ib = rand16();
    ic = rand16();
    va = sext16(ia);
    vb = sext16(ib);
    new_program();
    emit(i_type(mips_pkg::op_addi, 0, 1, ia));
    emit(i_type(mips_pkg::op_addi, 0, 2, ib));
    emit(r_type(1, 2, 3, mips_pkg::fn_add));
    emit(r_type(1, 2, 4, mips_pkg::fn_sub));
    emit(r_type(1, 2, 5, mips_pkg::fn_and));
    emit(r_type(1, 2, 6, mips_pkg::fn_or));
    emit(r_type(1, 2, 7, mips_pkg::fn_slt));
    emit(r_type(2, 1, 8, mips_pkg::fn_slt));        // Both compare directions
    emit(i_type(mips_pkg::op_addiu, 1, 9, ic));
    emit(r_type(1, 2, 10, mips_pkg::fn_addu));
    emit(r_type(1, 2, 11, mips_pkg::fn_subu));
    for (int r = 3; r <= 11; r++)
      emit(i_type(mips_pkg::op_sw, 0, r, 16'h0100 + 16'(4 * r)));
    expect_store(32'h10c, va + vb);
    expect_store(32'h110, va - vb);
    expect_store(32'h114, va & vb);
    expect_store(32'h118, va | vb);
    expect_store(32'h11c, ($signed(va) < $signed(vb)) ? 32'd1 : 32'd0);
    expect_store(32'h120, ($signed(vb) < $signed(va)) ? 32'd1 : 32'd0);
    expect_store(32'h124, va + sext16(ic));
    expect_store(32'h128, va + vb);
    expect_store(32'h12c, va - vb);
    launch();
    finish_test("test_alu_ops");
  endtask

  task automatic test_forwarding();
    logic [15:0] k1;
    logic [15:0] k2;
    logic [15:0] k3;
    logic [31:0] r2;
    logic [31:0] r4;
    logic [31:0] r7;
    k1 = rand16();
    k2 = rand16();
    k3 = rand16();
    r2 = sext16(k1) + sext16(k1);
    r4 = r2 - sext16(k1);
    r7 = (sext16(k2) | r4) + sext16(k3);
    new_program();
    emit(i_type(mips_pkg::op_addi, 0, 1, k1));
    emit(r_type(1, 1, 2, mips_pkg::fn_add));         // One back
    emit(i_type(mips_pkg::op_addi, 0, 3, k2));
    emit(r_type(2, 1, 4, mips_pkg::fn_sub));         // Two back and three back
    emit(r_type(3, 4, 5, mips_pkg::fn_or));
    emit(i_type(mips_pkg::op_addi, 0, 6, k3));
    emit(r_type(5, 6, 7, mips_pkg::fn_add));
    emit(i_type(mips_pkg::op_sw, 0, 7, 16'h0180));   // Store data forwarded
    emit(i_type(mips_pkg::op_sw, 0, 4, 16'h0184));
    emit(i_type(mips_pkg::op_sw, 0, 2, 16'h0188));
    expect_store(32'h180, r7);
    expect_store(32'h184, r4);
    expect_store(32'h188, r2);
    launch();
    finish_test("test_forwarding");
  endtask

  task automatic test_load_use();
    logic [15:0] a;
    logic [15:0] b;
    a = rand16();
    b = rand16();
    new_program();
    emit(i_type(mips_pkg::op_addi, 0, 1, a));
    emit(i_type(mips_pkg::op_addi, 0, 2, b));
    emit(i_type(mips_pkg::op_sw, 0, 1, 16'h01c0));
    emit(i_type(mips_pkg::op_lw, 0, 3, 16'h01c0));
    emit(r_type(3, 2, 4, mips_pkg::fn_add));         // Uses the load at once
    emit(i_type(mips_pkg::op_sw, 0, 4, 16'h01c4));
    emit(i_type(mips_pkg::op_lw, 0, 5, 16'h01c0));
    emit(i_type(mips_pkg::op_sw, 0, 5, 16'h01c8));
    emit(i_type(mips_pkg::op_lw, 0, 6, 16'h01c4));
    emit(i_type(mips_pkg::op_addi, 6, 7, 16'h0001));
    emit(i_type(mips_pkg::op_sw, 0, 7, 16'h01cc));
    expect_store(32'h1c0, sext16(a));
    expect_store(32'h1c4, sext16(a) + sext16(b));
    expect_store(32'h1c8, sext16(a));
    expect_store(32'h1cc, sext16(a) + sext16(b) + 32'd1);
    launch();
    finish_test("test_load_use");
  endtask

  task automatic test_branch();
    new_program();
    emit(i_type(mips_pkg::op_addi, 0, 1, 16'd7));
    emit(i_type(mips_pkg::op_addi, 0, 2, 16'd7));
    emit(i_type(mips_pkg::op_addi, 0, 3, 16'd9));
    emit(i_type(mips_pkg::op_beq, 1, 2, 16'd2));     // Taken and skips two
    emit(i_type(mips_pkg::op_sw, 0, 1, 16'h0200));   // Wrong path
    emit(i_type(mips_pkg::op_sw, 0, 1, 16'h0204));   // Wrong path
    emit(i_type(mips_pkg::op_sw, 0, 3, 16'h0208));
    emit(i_type(mips_pkg::op_beq, 1, 3, 16'd1));     // Not taken
    emit(i_type(mips_pkg::op_sw, 0, 2, 16'h020c));
    expect_store(32'h208, 32'd9);
    expect_store(32'h20c, 32'd7);
    launch();
    finish_test("test_branch");
  endtask

  task automatic test_reset_zero();
    new_program();
    emit(i_type(mips_pkg::op_addi, 0, 0, 16'd123));
    emit(i_type(mips_pkg::op_sw, 0, 0, 16'h0240));
    emit(i_type(mips_pkg::op_addi, 0, 0, 16'd77));
    emit(i_type(mips_pkg::op_addi, 0, 9, 16'd1));
    emit(i_type(mips_pkg::op_addi, 0, 10, 16'd2));
    emit(i_type(mips_pkg::op_sw, 0, 0, 16'h0244));   // Three after the r0 write
    emit(i_type(mips_pkg::op_sw, 0, 9, 16'h0248));
    expect_store(32'h240, 32'd0);
    expect_store(32'h244, 32'd0);
    expect_store(32'h248, 32'd1);
    for (int i = 0; i < 256; i++)
      imem[i] = i_type(mips_pkg::op_sw, 0, 0, 16'h0380);   // Stores in flight at reset
    while (!dmem_we)
      @(negedge clk);
    launch();
    check("imem_addr", imem_addr, 32'd0);
    check("dmem_we", {31'd0, dmem_we}, 32'd0);
    finish_test("test_reset_zero");
  endtask

  initial
  begin
    for (int i = 0; i < 256; i++)
    begin
      imem[i] = '0;
      dmem[i] = 32'ha5a5_0000 + i * 4;       // Low half holds the byte address
    end
    void'($urandom(8));
    test_alu_ops();
    test_forwarding();
    test_load_use();
    test_branch();
    test_reset_zero();
    $display("summary: %0d tests, %0d with errors, %0d checks, %0d mismatches",
             tests_run, tests_bad, check_count, error_count);
    if (error_count == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== bench/mips_asserts.sv ====
`default_nettype none

module mips_asserts (
  input logic                clk,
  input logic                reset,
  input logic                dmem_we,
  input logic                stall,
  input logic                flush,
  input mips_pkg::word_t     pc,
  input mips_pkg::if_id_t    if_id_q,
  input mips_pkg::id_ex_t    id_d,
  input mips_pkg::id_ex_t    id_ex_q
);
  timeunit 1ns;
  timeprecision 100ps;

  // ------------------------------------------------------------
  // Pipeline control properties
  // ------------------------------------------------------------
  a_no_store_near_reset: assert property (@(posedge clk)
    ($past(reset) || $past(reset, 2)) |-> !dmem_we)
    else $error("dmem_we high during or just after reset");

  a_r0_reads_zero: assert property (@(posedge clk) disable iff (reset)
    (id_d.rs == '0 |-> id_d.rs_val == '0) and (id_d.rt == '0 |-> id_d.rt_val == '0))
    else $error("register 0 source carries a nonzero value in decode");

  // PC and fetch/decode register both hold through the stall
  a_stall_holds_pc: assert property (@(posedge clk) disable iff (reset)
    stall |=> pc == $past(pc) && if_id_q == $past(if_id_q))
    else $error("PC or fetch/decode register moved during a load-use stall");

  // The stall bubble reaches execute with no control bits
  a_no_flush_on_stall: assert property (@(posedge clk) disable iff (reset)
    stall |=> id_ex_q.ctrl == '0 && !flush)
    else $error("load-use bubble carried control bits or raised flush");

endmodule

bind mips_pipeline mips_asserts u_asserts (
  .clk     (clk),
  .reset   (reset),
  .dmem_we (dmem_we),
  .stall   (stall),
  .flush   (flush),
  .pc      (pc),
  .if_id_q (if_id_q),
  .id_d    (id_d),
  .id_ex_q (id_ex_q)
);

`default_nettype wire

// ==== hw/mips_pipeline.sv ====
`default_nettype none

module mips_pipeline (
  input  logic            clk,
  input  logic            reset,
  output mips_pkg::word_t imem_addr,
  input  mips_pkg::word_t imem_data,
  output mips_pkg::word_t dmem_addr,
  output mips_pkg::word_t dmem_wdata,
  output logic            dmem_we,
  input  mips_pkg::word_t dmem_rdata
);

  mips_pkg::word_t    pc;
  mips_pkg::word_t    pc_plus4;
  mips_pkg::word_t    branch_target;
  logic               branch_taken;
  logic               stall;
  logic               flush;
  mips_pkg::fwd_sel_t fwd_a;
  mips_pkg::fwd_sel_t fwd_b;
  logic               id_fwd_a;
  logic               id_fwd_b;

  mips_pkg::if_id_t   if_d, if_id_q;
  mips_pkg::id_ex_t   id_d, id_ex_q;
  mips_pkg::ex_mem_t  ex_d, ex_mem_q;
  mips_pkg::mem_wb_t  mem_d, mem_wb_q;

  mips_pkg::ctrl_t    id_ctrl;
  mips_pkg::alu_op_t  id_alu_op;
  mips_pkg::word_t    rf_rd1, rf_rd2;
  mips_pkg::word_t    wb_result;

  // ------------------------------------------------------------
  // Fetch
  // ------------------------------------------------------------
  assign pc_plus4  = pc + mips_pkg::pc_step;
  assign imem_addr = pc;

  always_ff @(posedge clk)
  begin
    if (reset)
      pc <= '0;
    else if (!stall)
      pc <= branch_taken ? branch_target : pc_plus4;
  end

  assign if_d = '{instr: imem_data, pc_plus4: pc_plus4};

  pipe_reg #(.payload_t(mips_pkg::if_id_t)) if_id_reg (
    .clk   (clk),
    .reset (reset),
    .hold  (stall),
    .clear (flush),   // Wrong-path fetch becomes a bubble
    .d     (if_d),
    .q     (if_id_q)
  );

  // ------------------------------------------------------------
  // Decode
  // ------------------------------------------------------------
  control_decoder u_ctrl (
    .opcode (if_id_q.instr[31:26]),
    .funct  (if_id_q.instr[5:0]),
    .ctrl   (id_ctrl),
    .alu_op (id_alu_op)
  );

  register_file u_rf (
    .clk (clk),
    .we  (mem_wb_q.reg_write),
    .ra1 (if_id_q.instr[25:21]),
    .ra2 (if_id_q.instr[20:16]),
    .wa  (mem_wb_q.dest),
    .wd  (wb_result),
    .rd1 (rf_rd1),
    .rd2 (rf_rd2)
  );

  always_comb
  begin
    id_d.ctrl     = (stall || flush) ? '0 : id_ctrl;   // Bubble into execute
    id_d.alu_op   = id_alu_op;
    id_d.pc_plus4 = if_id_q.pc_plus4;
    id_d.rs_val   = id_fwd_a ? wb_result : rf_rd1;
    id_d.rt_val   = id_fwd_b ? wb_result : rf_rd2;
    id_d.imm      = {{(mips_pkg::data_width - 16){if_id_q.instr[15]}}, if_id_q.instr[15:0]};
    id_d.rs       = if_id_q.instr[25:21];
    id_d.rt       = if_id_q.instr[20:16];
    id_d.rd       = if_id_q.instr[15:11];
  end

  pipe_reg #(.payload_t(mips_pkg::id_ex_t)) id_ex_reg (
    .clk   (clk),
    .reset (reset),
    .hold  (1'b0),
    .clear (1'b0),
    .d     (id_d),
    .q     (id_ex_q)
  );

  hazard_unit u_hazard (
    .id_rs         (if_id_q.instr[25:21]),
    .id_rt         (if_id_q.instr[20:16]),
    .ex_rs         (id_ex_q.rs),
    .ex_rt         (id_ex_q.rt),
    .ex_mem_read   (id_ex_q.ctrl.mem_read),
    .branch_taken  (branch_taken),
    .mem_reg_write (ex_mem_q.reg_write),
    .mem_dest      (ex_mem_q.dest),
    .wb_reg_write  (mem_wb_q.reg_write),
    .wb_dest       (mem_wb_q.dest),
    .fwd_a         (fwd_a),
    .fwd_b         (fwd_b),
    .id_fwd_a      (id_fwd_a),
    .id_fwd_b      (id_fwd_b),
    .stall         (stall),
    .flush         (flush)
  );

  // ------------------------------------------------------------
  // Execute, memory, write-back
  // ------------------------------------------------------------
  execute_stage u_ex (
    .ex             (id_ex_q),
    .fwd_a          (fwd_a),
    .fwd_b          (fwd_b),
    .mem_alu_result (ex_mem_q.alu_result),
    .wb_result      (wb_result),
    .ex_out         (ex_d),
    .branch_taken   (branch_taken),
    .branch_target  (branch_target)
  );

  pipe_reg #(.payload_t(mips_pkg::ex_mem_t)) ex_mem_reg (
    .clk   (clk),
    .reset (reset),
    .hold  (1'b0),
    .clear (1'b0),
    .d     (ex_d),
    .q     (ex_mem_q)
  );

  assign dmem_addr  = ex_mem_q.alu_result;
  assign dmem_wdata = ex_mem_q.store_data;
  assign dmem_we    = ex_mem_q.mem_write;

  always_comb
  begin
    mem_d.mem_to_reg = ex_mem_q.mem_to_reg;
    mem_d.reg_write  = ex_mem_q.reg_write;
    mem_d.read_data  = dmem_rdata;
    mem_d.alu_result = ex_mem_q.alu_result;
    mem_d.dest       = ex_mem_q.dest;
  end

  pipe_reg #(.payload_t(mips_pkg::mem_wb_t)) mem_wb_reg (
    .clk   (clk),
    .reset (reset),
    .hold  (1'b0),
    .clear (1'b0),
    .d     (mem_d),
    .q     (mem_wb_q)
  );

  assign wb_result = mem_wb_q.mem_to_reg ? mem_wb_q.read_data : mem_wb_q.alu_result;

endmodule

`default_nettype wire

// ==== hw/execute_stage.sv ====
`default_nettype none

module execute_stage (
  input  mips_pkg::id_ex_t   ex,
  input  mips_pkg::fwd_sel_t fwd_a,
  input  mips_pkg::fwd_sel_t fwd_b,
  input  mips_pkg::word_t    mem_alu_result,
  input  mips_pkg::word_t    wb_result,
  output mips_pkg::ex_mem_t  ex_out,
  output logic               branch_taken,
  output mips_pkg::word_t    branch_target
);

  mips_pkg::word_t src_a;
  mips_pkg::word_t rt_fwd;
  mips_pkg::word_t src_b;
  mips_pkg::word_t alu_result;

  // ------------------------------------------------------------
  // Operand forwarding
  // ------------------------------------------------------------
  always_comb
  begin
    case (fwd_a)
      mips_pkg::fwd_mem: src_a = mem_alu_result;
      mips_pkg::fwd_wb:  src_a = wb_result;
      default:           src_a = ex.rs_val;
    endcase
    case (fwd_b)
      mips_pkg::fwd_mem: rt_fwd = mem_alu_result;
      mips_pkg::fwd_wb:  rt_fwd = wb_result;
      default:           rt_fwd = ex.rt_val;
    endcase
  end

  assign src_b = ex.ctrl.alu_src ? ex.imm : rt_fwd;

  // ------------------------------------------------------------
  // ALU
  // ------------------------------------------------------------
  always_comb
  begin
    case (ex.alu_op)
      mips_pkg::alu_add: alu_result = src_a + src_b;
      mips_pkg::alu_sub: alu_result = src_a - src_b;
      mips_pkg::alu_and: alu_result = src_a & src_b;
      mips_pkg::alu_or:  alu_result = src_a | src_b;
      mips_pkg::alu_slt:
        alu_result = ($signed(src_a) < $signed(src_b)) ? 32'd1 : 32'd0;   // Signed compare
      default:           alu_result = src_a + src_b;
    endcase
  end

  // beq decodes to a subtract, equal operands give zero
  assign branch_target = ex.pc_plus4 + (ex.imm << 2);
  assign branch_taken  = ex.ctrl.branch && alu_result == '0;

  always_comb
  begin
    ex_out.mem_write  = ex.ctrl.mem_write;
    ex_out.mem_to_reg = ex.ctrl.mem_to_reg;
    ex_out.reg_write  = ex.ctrl.reg_write;
    ex_out.alu_result = alu_result;
    ex_out.store_data = rt_fwd;                           // sw data sees forwarding too
    ex_out.dest       = ex.ctrl.reg_dst ? ex.rd : ex.rt;
  end

endmodule

`default_nettype wire

// ==== hw/hazard_unit.sv ====
`default_nettype none

module hazard_unit (
  input  mips_pkg::reg_addr_t id_rs,
  input  mips_pkg::reg_addr_t id_rt,
  input  mips_pkg::reg_addr_t ex_rs,
  input  mips_pkg::reg_addr_t ex_rt,
  input  logic                ex_mem_read,
  input  logic                branch_taken,
  input  logic                mem_reg_write,
  input  mips_pkg::reg_addr_t mem_dest,
  input  logic                wb_reg_write,
  input  mips_pkg::reg_addr_t wb_dest,
  output mips_pkg::fwd_sel_t  fwd_a,
  output mips_pkg::fwd_sel_t  fwd_b,
  output logic                id_fwd_a,
  output logic                id_fwd_b,
  output logic                stall,
  output logic                flush
);

  // Memory stage wins over write-back, it holds the younger result
  function automatic mips_pkg::fwd_sel_t ex_select(input mips_pkg::reg_addr_t src);
    if (src == '0)
      return mips_pkg::fwd_none;
    else if (mem_reg_write && mem_dest == src)
      return mips_pkg::fwd_mem;
    else if (wb_reg_write && wb_dest == src)
      return mips_pkg::fwd_wb;
    else
      return mips_pkg::fwd_none;
  endfunction

  assign fwd_a = ex_select(ex_rs);
  assign fwd_b = ex_select(ex_rt);

  // Register file write lands at the edge, so decode bypasses it
  assign id_fwd_a = wb_reg_write && wb_dest == id_rs && id_rs != '0;
  assign id_fwd_b = wb_reg_write && wb_dest == id_rt && id_rt != '0;

  // Load result is not ready until memory, hold decode one cycle
  assign stall = ex_mem_read && ex_rt != '0 && (ex_rt == id_rs || ex_rt == id_rt);
  assign flush = branch_taken;

endmodule

`default_nettype wire

// ==== hw/pipe_reg.sv ====
`default_nettype none

module pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     hold,
  input  logic     clear,
  input  payload_t d,
  output payload_t q
);

  always_ff @(posedge clk)
  begin
    if (reset || clear)
      q <= '0;          // Zero payload is a bubble
    else if (!hold)
      q <= d;
  end

endmodule

`default_nettype wire

// ==== hw/register_file.sv ====
`default_nettype none

module register_file (
  input  logic               clk,
  input  logic               we,
  input  mips_pkg::reg_addr_t ra1,
  input  mips_pkg::reg_addr_t ra2,
  input  mips_pkg::reg_addr_t wa,
  input  mips_pkg::word_t     wd,
  output mips_pkg::word_t     rd1,
  output mips_pkg::word_t     rd2
);

  mips_pkg::word_t regs [32];

  always_ff @(posedge clk)
  begin
    if (we && wa != '0)   // r0 stays zero
      regs[wa] <= wd;
  end

  // Combinational read, r0 hardwired
  assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
  assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

endmodule

`default_nettype wire

// ==== hw/control_decoder.sv ====
`default_nettype none

module control_decoder (
  input  logic [5:0]        opcode,
  input  logic [5:0]        funct,
  output mips_pkg::ctrl_t   ctrl,
  output mips_pkg::alu_op_t alu_op
);

  always_comb
  begin
    ctrl   = '0;                 // Unknown codes act as a no-op
    alu_op = mips_pkg::alu_add;
    case (opcode)
      mips_pkg::op_rtype:
      begin
        ctrl.reg_dst   = 1'b1;
        ctrl.reg_write = 1'b1;
        case (funct)
          mips_pkg::fn_add,
          mips_pkg::fn_addu: alu_op = mips_pkg::alu_add;
          mips_pkg::fn_sub,
          mips_pkg::fn_subu: alu_op = mips_pkg::alu_sub;
          mips_pkg::fn_and:  alu_op = mips_pkg::alu_and;
          mips_pkg::fn_or:   alu_op = mips_pkg::alu_or;
          mips_pkg::fn_slt:  alu_op = mips_pkg::alu_slt;
          default:           ctrl   = '0;   // Unsupported funct
        endcase
      end
      mips_pkg::op_lw:
      begin
        ctrl.alu_src    = 1'b1;
        ctrl.mem_read   = 1'b1;
        ctrl.mem_to_reg = 1'b1;
        ctrl.reg_write  = 1'b1;
      end
      mips_pkg::op_sw:
      begin
        ctrl.alu_src   = 1'b1;
        ctrl.mem_write = 1'b1;
      end
      mips_pkg::op_beq:
      begin
        ctrl.branch = 1'b1;
        alu_op      = mips_pkg::alu_sub;   // Zero result means equal
      end
      mips_pkg::op_addi,
      mips_pkg::op_addiu:
      begin
        ctrl.alu_src   = 1'b1;
        ctrl.reg_write = 1'b1;
      end
      default: ctrl = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== hw/mips_pkg.sv ====
`default_nettype none

package mips_pkg;

  localparam int data_width     = 32;
  localparam int reg_addr_width = 5;

  typedef logic [data_width-1:0]     word_t;
  typedef logic [reg_addr_width-1:0] reg_addr_t;

  localparam word_t pc_step = 32'd4;

  // ------------------------------------------------------------
  // Opcodes and R-type funct codes
  // ------------------------------------------------------------
  localparam logic [5:0] op_rtype = 6'b000000;
  localparam logic [5:0] op_lw    = 6'b100011;
  localparam logic [5:0] op_sw    = 6'b101011;
  localparam logic [5:0] op_beq   = 6'b000100;
  localparam logic [5:0] op_addi  = 6'b001000;
  localparam logic [5:0] op_addiu = 6'b001001;

  localparam logic [5:0] fn_add  = 6'b100000;
  localparam logic [5:0] fn_addu = 6'b100001;
  localparam logic [5:0] fn_sub  = 6'b100010;
  localparam logic [5:0] fn_subu = 6'b100011;
  localparam logic [5:0] fn_and  = 6'b100100;
  localparam logic [5:0] fn_or   = 6'b100101;
  localparam logic [5:0] fn_slt  = 6'b101010;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_slt
  } alu_op_t;

  typedef enum logic [1:0] {
    fwd_none,
    fwd_mem,
    fwd_wb
  } fwd_sel_t;

  typedef struct packed {
    logic reg_dst;    // Dest from rd instead of rt
    logic alu_src;    // Immediate as operand b
    logic branch;
    logic mem_read;
    logic mem_write;
    logic mem_to_reg;
    logic reg_write;
  } ctrl_t;

  // ------------------------------------------------------------
  // Stage payloads
  // ------------------------------------------------------------
  typedef struct packed {
    word_t instr;
    word_t pc_plus4;
  } if_id_t;

  typedef struct packed {
    ctrl_t     ctrl;
    alu_op_t   alu_op;
    word_t     pc_plus4;
    word_t     rs_val;
    word_t     rt_val;
    word_t     imm;      // Already sign-extended
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;
  } id_ex_t;

  typedef struct packed {
    logic      mem_write;
    logic      mem_to_reg;
    logic      reg_write;
    word_t     alu_result;
    word_t     store_data;
    reg_addr_t dest;
  } ex_mem_t;

  typedef struct packed {
    logic      mem_to_reg;
    logic      reg_write;
    word_t     read_data;
    word_t     alu_result;
    reg_addr_t dest;
  } mem_wb_t;

endpackage

`default_nettype wire
